// File: verilog/io_pkg.sv
package io_pkg;

    ////////////////////////////////////////
    // Address map and widths
    ////////////////////////////////////////

    // Base of the 256-byte I/O window
    localparam logic [31:0] IO_BASE_ADDR = 32'h0000_7F00;
    // In-window byte offset width
    localparam int IO_ADDR_BITS = 8;

    // CPU data bus width
    localparam int DATA_W = 32;
    // LED register, seven-segment data and switch vector
    localparam int LED_W = 16;

    // Seven-segment control layout
    // Bits 3..0 digit enables, bits 7..4 decimal points
    localparam int SEG_CTRL_W = 8;
    // All four digits lit, no points
    localparam logic [SEG_CTRL_W-1:0] SEG_CTRL_RESET = 8'h0F;

    localparam int NUM_BTN = 5;
    localparam int NUM_DIGITS = 4;

    ////////////////////////////////////////
    // Register index (address bits 5..2)
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        REG_LED      = 4'd0,
        REG_SW       = 4'd1,
        REG_SEG      = 4'd6,
        REG_SEG_CTRL = 4'd7,
        REG_BTN      = 4'd9,
        REG_TIMER    = 4'd12
    } io_reg_e;

    ////////////////////////////////////////
    // Bus and strobe bundles
    ////////////////////////////////////////

    // CPU request, sampled every cycle
    typedef struct packed {
        logic [31:0]       addr;
        logic              wr;
        logic              rd;
        logic [DATA_W-1:0] wdata;
    } io_req_t;

    // One-cycle write strobes, at most one high
    typedef struct packed {
        logic led;
        logic seg;
        logic seg_ctrl;
        logic timer;
    } io_wr_t;

    // Display pins, all active low
    // Segment a in bit 0 through g in bit 6
    typedef struct packed {
        logic [NUM_DIGITS-1:0] an;
        logic [6:0]            seg;
        logic                  dp;
    } seg_out_t;

endpackage

// File: verilog/io_bus.sv
`timescale 1ns/1ps

module io_bus (
    input  logic                          clk,
    input  logic                          rst,
    input  io_pkg::io_req_t               req_i,
    input  logic [io_pkg::LED_W-1:0]      sw_i,
    input  logic [io_pkg::NUM_BTN-1:0]    btn_i,
    input  logic [io_pkg::LED_W-1:0]      seg_data_i,
    input  logic [io_pkg::SEG_CTRL_W-1:0] seg_ctrl_i,
    input  logic [io_pkg::DATA_W-1:0]     timer_i,
    output io_pkg::io_wr_t                wr_o,
    output logic [io_pkg::LED_W-1:0]      led_o,
    output logic [io_pkg::DATA_W-1:0]     rdata_o,
    output logic                          rvalid_o
);

    ////////////////////////////////////////
    // Window and index decode
    ////////////////////////////////////////

    logic            in_win;
    io_pkg::io_reg_e reg_idx;
    logic [io_pkg::LED_W-1:0] led_q;

    // Upper 24 address bits select the window
    assign in_win = (req_i.addr[31:io_pkg::IO_ADDR_BITS] ==
                     io_pkg::IO_BASE_ADDR[31:io_pkg::IO_ADDR_BITS]);

    // Word index, byte lane bits ignored
    assign reg_idx = io_pkg::io_reg_e'(req_i.addr[5:2]);

    // Write strobes
    always_comb begin
        wr_o = '0;
        if (in_win && req_i.wr) begin
            case (reg_idx)
                io_pkg::REG_LED:      wr_o.led      = 1'b1;
                io_pkg::REG_SEG:      wr_o.seg      = 1'b1;
                io_pkg::REG_SEG_CTRL: wr_o.seg_ctrl = 1'b1;
                io_pkg::REG_TIMER:    wr_o.timer    = 1'b1;
                // Read-only and unmapped slots
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // LED register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            led_q <= '0;
        end else if (wr_o.led) begin
            led_q <= req_i.wdata[io_pkg::LED_W-1:0];
        end
    end

    assign led_o = led_q;

    ////////////////////////////////////////
    // Registered read path
    ////////////////////////////////////////

    // Data and valid one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            rvalid_o <= in_win;
            case (reg_idx)
                io_pkg::REG_LED:
                    rdata_o <= {{(io_pkg::DATA_W - io_pkg::LED_W){1'b0}}, led_q};
                io_pkg::REG_SW:
                    rdata_o <= {{(io_pkg::DATA_W - io_pkg::LED_W){1'b0}}, sw_i};
                io_pkg::REG_SEG:
                    rdata_o <= {{(io_pkg::DATA_W - io_pkg::LED_W){1'b0}}, seg_data_i};
                io_pkg::REG_SEG_CTRL:
                    rdata_o <= {{(io_pkg::DATA_W - io_pkg::SEG_CTRL_W){1'b0}}, seg_ctrl_i};
                io_pkg::REG_BTN:
                    rdata_o <= {{(io_pkg::DATA_W - io_pkg::NUM_BTN){1'b0}}, btn_i};
                io_pkg::REG_TIMER:
                    rdata_o <= timer_i;
                // Unmapped index holds the last value
                default: ;
            endcase
        end
    end

    // Only one register may capture a given write
    a_wr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(wr_o))
        else $error("io_bus: more than one write strobe high");

endmodule

// File: verilog/input_conditioner.sv
`timescale 1ns/1ps

module input_conditioner #(
    parameter int DEBOUNCE_CYCLES = 333333
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [io_pkg::LED_W-1:0]   sw_i,
    input  logic [io_pkg::NUM_BTN-1:0] btn_i,
    output logic [io_pkg::LED_W-1:0]   sw_o,
    output logic [io_pkg::NUM_BTN-1:0] btn_o
);

    // Stability counter width, at least one bit
    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic [io_pkg::LED_W-1:0]   sw_meta;
    logic [io_pkg::LED_W-1:0]   sw_sync;
    logic [io_pkg::NUM_BTN-1:0] btn_meta;
    logic [io_pkg::NUM_BTN-1:0] btn_sync;

    ////////////////////////////////////////
    // Two-flop synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sw_meta  <= '0;
            sw_sync  <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            sw_meta  <= sw_i;
            sw_sync  <= sw_meta;
            btn_meta <= btn_i;
            btn_sync <= btn_meta;
        end
    end

    // Switches are read straight from the second flop
    assign sw_o = sw_sync;

    ////////////////////////////////////////
    // Button debouncers
    ////////////////////////////////////////

    for (genvar i = 0; i < io_pkg::NUM_BTN; i++) begin : g_btn
        logic [CNT_W-1:0] cnt_q;
        logic             deb_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt_q <= '0;
                deb_q <= 1'b0;
            end else if (btn_sync[i] == deb_q) begin
                // Level agrees with output, restart
                cnt_q <= '0;
            end else if (cnt_q == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                // New level held long enough
                cnt_q <= '0;
                deb_q <= btn_sync[i];
            end else begin
                cnt_q <= cnt_q + CNT_W'(1);
            end
        end

        assign btn_o[i] = deb_q;
    end

endmodule

// File: verilog/seven_seg_display.sv
`timescale 1ns/1ps

module seven_seg_display #(
    parameter int SCAN_CYCLES = 8192
) (
    input  logic                          clk,
    input  logic                          rst,
    input  io_pkg::io_wr_t                wr_i,
    input  logic [io_pkg::DATA_W-1:0]     wdata_i,
    output logic [io_pkg::LED_W-1:0]      seg_data_o,
    output logic [io_pkg::SEG_CTRL_W-1:0] seg_ctrl_o,
    output io_pkg::seg_out_t              seg_o
);

    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam int DIG_W  = $clog2(io_pkg::NUM_DIGITS);

    logic [io_pkg::LED_W-1:0]      data_q;
    logic [io_pkg::SEG_CTRL_W-1:0] ctrl_q;
    logic [SCAN_W-1:0]             scan_q;
    logic [DIG_W-1:0]              digit_q;
    logic                          scan_en_q;
    logic [3:0]                    nibble;

    // Active-low pattern, a in bit 0
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        logic [6:0] lit;
        case (hex)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    ////////////////////////////////////////
    // Data and control registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= '0;
            ctrl_q <= io_pkg::SEG_CTRL_RESET;
        end else begin
            if (wr_i.seg)
                data_q <= wdata_i[io_pkg::LED_W-1:0];
            if (wr_i.seg_ctrl)
                ctrl_q <= wdata_i[io_pkg::SEG_CTRL_W-1:0];
        end
    end

    assign seg_data_o = data_q;
    assign seg_ctrl_o = ctrl_q;

    ////////////////////////////////////////
    // Digit scanner
    ////////////////////////////////////////

    // scan_en_q keeps the display dark until reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_q    <= '0;
            digit_q   <= '0;
            scan_en_q <= 1'b0;
        end else begin
            scan_en_q <= 1'b1;
            if (scan_q == SCAN_W'(SCAN_CYCLES - 1)) begin
                scan_q <= '0;
                // Wrap after the last digit
                if (digit_q == DIG_W'(io_pkg::NUM_DIGITS - 1))
                    digit_q <= '0;
                else
                    digit_q <= digit_q + DIG_W'(1);
            end else begin
                scan_q <= scan_q + SCAN_W'(1);
            end
        end
    end

    // Pin drive for the current digit
    assign nibble = data_q[digit_q*4 +: 4];

    always_comb begin
        seg_o = '1;
        // Disabled digit leaves its anode high
        seg_o.an[digit_q] = ~(scan_en_q & ctrl_q[digit_q]);
        seg_o.seg = hex_to_seg(nibble);
        seg_o.dp  = ~ctrl_q[io_pkg::NUM_DIGITS + digit_q];
    end

    // Never two digits on together
    a_one_anode: assert property (@(posedge clk) disable iff (rst) $onehot0(~seg_o.an))
        else $error("seven_seg_display: more than one anode low");

endmodule

// File: verilog/ms_timer.sv
`timescale 1ns/1ps

module ms_timer #(
    parameter int CLOCKS_PER_MS = 33333
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_i,
    input  logic [io_pkg::DATA_W-1:0] wdata_i,
    output logic [io_pkg::DATA_W-1:0] count_o
);

    localparam int PRE_W = (CLOCKS_PER_MS > 1) ? $clog2(CLOCKS_PER_MS) : 1;

    logic [PRE_W-1:0]          pre_q;
    logic [io_pkg::DATA_W-1:0] count_q;

    ////////////////////////////////////////
    // Prescaler and millisecond count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_q   <= '0;
            count_q <= '0;
        end else if (load_i) begin
            // CPU write restarts the current millisecond
            pre_q   <= '0;
            count_q <= wdata_i;
        end else if (pre_q == PRE_W'(CLOCKS_PER_MS - 1)) begin
            pre_q   <= '0;
            count_q <= count_q + 1'b1;
        end else begin
            pre_q <= pre_q + PRE_W'(1);
        end
    end

    assign count_o = count_q;

    // Terminal count is always hit before overflow
    a_pre_range: assert property (@(posedge clk) disable iff (rst)
        32'(pre_q) < CLOCKS_PER_MS)
        else $error("ms_timer: prescaler out of range");

endmodule

// File: verilog/io_system.sv
`timescale 1ns/1ps

module io_system #(
    parameter int DEBOUNCE_CYCLES = 333333,
    parameter int SCAN_CYCLES     = 8192,
    parameter int CLOCKS_PER_MS   = 33333
) (
    input  logic                       clk,
    input  logic                       rst,
    input  io_pkg::io_req_t            req_i,
    input  logic [io_pkg::LED_W-1:0]   sw_i,
    input  logic [io_pkg::NUM_BTN-1:0] btn_i,
    output logic [io_pkg::DATA_W-1:0]  rdata_o,
    output logic                       rvalid_o,
    output logic [io_pkg::LED_W-1:0]   led_o,
    output io_pkg::seg_out_t           seg_o
);

    io_pkg::io_wr_t                wr;
    logic [io_pkg::LED_W-1:0]      sw_sync;
    logic [io_pkg::NUM_BTN-1:0]    btn_deb;
    logic [io_pkg::LED_W-1:0]      seg_data;
    logic [io_pkg::SEG_CTRL_W-1:0] seg_ctrl;
    logic [io_pkg::DATA_W-1:0]     timer_count;

    ////////////////////////////////////////
    // Decode, LEDs and read path
    ////////////////////////////////////////

    io_bus u_bus (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .sw_i       (sw_sync),
        .btn_i      (btn_deb),
        .seg_data_i (seg_data),
        .seg_ctrl_i (seg_ctrl),
        .timer_i    (timer_count),
        .wr_o       (wr),
        .led_o      (led_o),
        .rdata_o    (rdata_o),
        .rvalid_o   (rvalid_o)
    );

    // Switch and button conditioning
    input_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_cond (
        .clk   (clk),
        .rst   (rst),
        .sw_i  (sw_i),
        .btn_i (btn_i),
        .sw_o  (sw_sync),
        .btn_o (btn_deb)
    );

    // Four-digit display
    seven_seg_display #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_disp (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (wr),
        .wdata_i    (req_i.wdata),
        .seg_data_o (seg_data),
        .seg_ctrl_o (seg_ctrl),
        .seg_o      (seg_o)
    );

    // Millisecond timer, loaded by its strobe
    ms_timer #(
        .CLOCKS_PER_MS (CLOCKS_PER_MS)
    ) u_timer (
        .clk     (clk),
        .rst     (rst),
        .load_i  (wr.timer),
        .wdata_i (req_i.wdata),
        .count_o (timer_count)
    );

endmodule

// File: sim/tb_io_system.sv
`timescale 1ns/1ps

module tb_io_system;

    // Short counts so every behavior fits in a few cycles
    localparam int DEBOUNCE = 4;
    localparam int SCAN     = 4;
    localparam int CPMS     = 10;

    // Control register after reset, all four digits on and no points
    localparam logic [7:0] CTRL_AT_RESET = 8'h0F;

    ////////////////////////////////////////
    // Cycle budget per test
    ////////////////////////////////////////

    localparam int LEN_RESET   = 20;
    localparam int LEN_REGS    = 200 * 2;
    localparam int LEN_WINDOW  = 50 + 20 + 10;
    localparam int LEN_INPUTS  = 20 * 5 + 4 * 2 * (DEBOUNCE + 5) + 6 * (DEBOUNCE + 6);
    localparam int LEN_TIMER   = 20 * (3 * CPMS + 6);
    localparam int LEN_DISPLAY = 10 * (4 * SCAN + 4);
    localparam int LEN_TOTAL   = LEN_RESET + LEN_REGS + LEN_WINDOW + LEN_INPUTS
                                 + LEN_TIMER + LEN_DISPLAY;
    // 20% margin on top
    localparam int TIMEOUT_CYCLES = LEN_TOTAL + LEN_TOTAL / 5;

    logic                          clk;
    logic                          rst;
    io_pkg::io_req_t               req;
    logic [io_pkg::LED_W-1:0]      sw;
    logic [io_pkg::NUM_BTN-1:0]    btn;
    logic [io_pkg::DATA_W-1:0]     rdata;
    logic                          rvalid;
    logic [io_pkg::LED_W-1:0]      led;
    io_pkg::seg_out_t              seg_out;

    // Reference model state
    logic [io_pkg::LED_W-1:0]      m_led;
    logic [io_pkg::LED_W-1:0]      m_seg;
    logic [io_pkg::SEG_CTRL_W-1:0] m_ctrl;

    integer seed;
    int     errors;
    int     errors_at_start;
    int     tests_done;
    int     cycles;

    io_system #(
        .DEBOUNCE_CYCLES (DEBOUNCE),
        .SCAN_CYCLES     (SCAN),
        .CLOCKS_PER_MS   (CPMS)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .req_i    (req),
        .sw_i     (sw),
        .btn_i    (btn),
        .rdata_o  (rdata),
        .rvalid_o (rvalid),
        .led_o    (led),
        .seg_o    (seg_out)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] reg_addr(input io_pkg::io_reg_e idx);
        return io_pkg::IO_BASE_ADDR | {26'd0, idx, 2'b00};
    endfunction

    // Expected read value, upper bits zero
    function automatic logic [31:0] model_value(input io_pkg::io_reg_e idx);
        case (idx)
            io_pkg::REG_LED:      return {16'd0, m_led};
            io_pkg::REG_SEG:      return {16'd0, m_seg};
            io_pkg::REG_SEG_CTRL: return {24'd0, m_ctrl};
            default:              return 32'd0;
        endcase
    endfunction

    // Lit segments by letter, then inverted for the active-low pins
    function automatic logic [6:0] seg_pattern(input logic [3:0] hex);
        string      lit;
        logic [6:0] on;
        case (hex)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'hA: lit = "abcefg";
            4'hB: lit = "cdefg";
            4'hC: lit = "adef";
            4'hD: lit = "bcdeg";
            4'hE: lit = "adefg";
            default: lit = "aefg";
        endcase
        on = '0;
        for (int k = 0; k < lit.len(); k++) begin
            on[lit[k] - "a"] = 1'b1;
        end
        return ~on;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        errors++;
        $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("Test %0d (%s) done: %0d errors", tests_done, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // Bus tasks start and end just after a falling edge
    task automatic idle_cycle();
        req = '0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic bus_write(input io_pkg::io_reg_e idx, input logic [31:0] data);
        req       = '0;
        req.addr  = reg_addr(idx);
        req.wr    = 1'b1;
        req.wdata = data;
        @(posedge clk);
        @(negedge clk);
        req = '0;
        case (idx)
            io_pkg::REG_LED:      m_led  = data[15:0];
            io_pkg::REG_SEG:      m_seg  = data[15:0];
            io_pkg::REG_SEG_CTRL: m_ctrl = data[7:0];
            default: ;
        endcase
    endtask

    // Data and valid sampled one edge after the address
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic valid);
        req      = '0;
        req.addr = addr;
        req.rd   = 1'b1;
        @(posedge clk);
        @(negedge clk);
        data  = rdata;
        valid = rvalid;
        req   = '0;
    endtask

    task automatic expect_read(input io_pkg::io_reg_e idx, input logic [31:0] exp,
                               input string label);
        logic [31:0] data;
        logic        valid;
        bus_read(reg_addr(idx), data, valid);
        if (valid !== 1'b1) show_mismatch("rvalid_o", 32'd1, {31'd0, valid});
        if (data !== exp) show_mismatch(label, exp, data);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic run_reset_test();
        // Display dark while reset is held
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            if (seg_out.an !== 4'hF) show_mismatch("seg_o.an", 32'hF, {28'd0, seg_out.an});
        end
        rst = 1'b0;
        if (rvalid !== 1'b0) show_mismatch("rvalid_o", 32'd0, {31'd0, rvalid});
        if (led !== '0) show_mismatch("led_o", 32'd0, {16'd0, led});
        expect_read(io_pkg::REG_SEG_CTRL, {24'd0, CTRL_AT_RESET}, "rdata_o (seg ctrl)");
        expect_read(io_pkg::REG_SEG, 32'd0, "rdata_o (seg data)");
        expect_read(io_pkg::REG_LED, 32'd0, "rdata_o (led)");
        end_test("reset values");
    endtask

    task automatic run_register_test();
        int              op;
        io_pkg::io_reg_e idx;
        for (int i = 0; i < 200; i++) begin
            op = rand_below(6);
            case (op % 3)
                0: idx = io_pkg::REG_LED;
                1: idx = io_pkg::REG_SEG;
                default: idx = io_pkg::REG_SEG_CTRL;
            endcase
            if (op < 3) begin
                bus_write(idx, $random(seed));
                if (led !== m_led) show_mismatch("led_o", {16'd0, m_led}, {16'd0, led});
            end else begin
                expect_read(idx, model_value(idx), "rdata_o (register)");
            end
        end
        end_test("register write and read");
    endtask

    task automatic run_window_test();
        logic [31:0] addr;
        logic [31:0] data;
        logic        valid;
        // Writes outside the window must not land
        for (int i = 0; i < 50; i++) begin
            addr = $random(seed);
            if (addr[31:8] == io_pkg::IO_BASE_ADDR[31:8]) addr[20] = ~addr[20];
            req       = '0;
            req.addr  = addr;
            req.wr    = 1'b1;
            req.rd    = 1'b1;
            req.wdata = $random(seed);
            @(posedge clk);
            @(negedge clk);
            if (rvalid !== 1'b0) show_mismatch("rvalid_o", 32'd0, {31'd0, rvalid});
            if (led !== m_led) show_mismatch("led_o", {16'd0, m_led}, {16'd0, led});
        end
        expect_read(io_pkg::REG_LED, model_value(io_pkg::REG_LED), "rdata_o (led)");
        expect_read(io_pkg::REG_SEG, model_value(io_pkg::REG_SEG), "rdata_o (seg data)");
        expect_read(io_pkg::REG_SEG_CTRL, model_value(io_pkg::REG_SEG_CTRL),
                    "rdata_o (seg ctrl)");
        // Any offset inside the window is valid
        for (int i = 0; i < 20; i++) begin
            addr = io_pkg::IO_BASE_ADDR | ($random(seed) & 32'hFF);
            bus_read(addr, data, valid);
            if (valid !== 1'b1) show_mismatch("rvalid_o", 32'd1, {31'd0, valid});
        end
        end_test("window decode");
    endtask

    task automatic run_input_test();
        logic [31:0] data;
        logic [4:0]  mask;
        int          width;
        // Switches need two edges through the synchronizer
        for (int i = 0; i < 20; i++) begin
            data = $random(seed);
            sw   = data[15:0];
            repeat (2 + rand_below(3)) idle_cycle();
            expect_read(io_pkg::REG_SW, {16'd0, sw}, "rdata_o (switches)");
        end
        // Held buttons, then release
        for (int i = 0; i < 4; i++) begin
            data = $random(seed);
            mask = (data[4:0] == 5'd0) ? 5'b00001 : data[4:0];
            btn  = mask;
            repeat (DEBOUNCE + 4) idle_cycle();
            expect_read(io_pkg::REG_BTN, {27'd0, mask}, "rdata_o (buttons held)");
            btn = '0;
            repeat (DEBOUNCE + 4) idle_cycle();
            expect_read(io_pkg::REG_BTN, 32'd0, "rdata_o (buttons released)");
        end
        // Short pulses are filtered out
        for (int i = 0; i < 6; i++) begin
            data  = $random(seed);
            mask  = (data[4:0] == 5'd0) ? 5'b10000 : data[4:0];
            width = 1 + rand_below(DEBOUNCE - 1);
            for (int c = 0; c < DEBOUNCE + 6; c++) begin
                btn = (c < width) ? mask : 5'd0;
                expect_read(io_pkg::REG_BTN, 32'd0, "rdata_o (short pulse)");
            end
        end
        end_test("input conditioning");
    endtask

    task automatic run_timer_test();
        logic [31:0] load;
        int          m;
        for (int i = 0; i < 20; i++) begin
            load = $random(seed);
            // First load checks the wrap
            if (i == 0) load = 32'hFFFF_FFFF;
            m = 1 + rand_below(3 * CPMS + 5);
            // Wait long enough for at least one step past the top
            if (i == 0 && m <= CPMS) m = m + CPMS;
            bus_write(io_pkg::REG_TIMER, load);
            repeat (m - 1) idle_cycle();
            expect_read(io_pkg::REG_TIMER, load + 32'((m - 1) / CPMS), "rdata_o (timer)");
        end
        end_test("timer");
    endtask

    task automatic run_display_test();
        logic [31:0] data;
        logic [3:0]  seen;
        logic [3:0]  low;
        int          digit;
        for (int r = 0; r < 10; r++) begin
            bus_write(io_pkg::REG_SEG, $random(seed));
            data = $random(seed);
            // All digits on in the first round
            if (r == 0) data[3:0] = 4'hF;
            bus_write(io_pkg::REG_SEG_CTRL, data);
            seen = '0;
            for (int c = 0; c < 4 * SCAN + 2; c++) begin
                low = ~seg_out.an;
                if ($countones(low) > 1) begin
                    errors++;
                    $display("Error at %0t: more than one anode low (0x%0h)", $time, low);
                end else if (low != 4'd0) begin
                    digit = 0;
                    for (int d = 0; d < 4; d++) begin
                        if (low[d]) digit = d;
                    end
                    seen[digit] = 1'b1;
                    if (!m_ctrl[digit]) begin
                        errors++;
                        $display("Error at %0t: anode of disabled digit %0d low", $time, digit);
                    end
                    if (seg_out.seg !== seg_pattern(m_seg[digit*4 +: 4]))
                        show_mismatch("seg_o.seg", {25'd0, seg_pattern(m_seg[digit*4 +: 4])},
                                      {25'd0, seg_out.seg});
                    if (seg_out.dp !== ~m_ctrl[4 + digit])
                        show_mismatch("seg_o.dp", {31'd0, ~m_ctrl[4 + digit]},
                                      {31'd0, seg_out.dp});
                end
                idle_cycle();
            end
            for (int d = 0; d < 4; d++) begin
                if (m_ctrl[d] && !seen[d]) begin
                    errors++;
                    $display("Error at %0t: enabled digit %0d never lit in one scan", $time, d);
                end
            end
        end
        end_test("display");
    endtask

    initial begin
        seed            = 92;
        rst             = 1'b1;
        req             = '0;
        sw              = '0;
        btn             = '0;
        errors          = 0;
        errors_at_start = 0;
        tests_done      = 0;
        cycles          = 0;
        m_led           = '0;
        m_seg           = '0;
        m_ctrl          = CTRL_AT_RESET;
        run_reset_test();
        run_register_test();
        run_window_test();
        run_input_test();
        run_timer_test();
        run_display_test();
        $display("Summary: %0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/io_pkg.sv
verilog/io_bus.sv
verilog/input_conditioner.sv
verilog/seven_seg_display.sv
verilog/ms_timer.sv
verilog/io_system.sv
sim/tb_io_system.sv

// File: Makefile
# Verilator build and run for the I/O block testbench
VERILATOR ?= verilator
TOP       ?= tb_io_system
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
